//--- bench/icache_tb.sv
// testbench for the instruction cache, runs directed and random fetches against a reference model
`timescale 1ns/1ps

module tb_icache;

    localparam int index_width = 4;
    localparam int tag_width = 28 - index_width;
    localparam int sets = 1 << index_width;
    localparam int n_directed = 16;
    localparam int n_random = 300;
    localparam int max_cycles = 40 * (n_directed + n_random) + 200;

    logic clk;
    logic reset;
    logic req_valid;
    logic [31:0] req_addr;
    logic req_ready;
    logic rsp_valid;
    icache_pkg::fetch_rsp_t rsp;
    logic inval;
    logic mem_req;
    icache_pkg::mem_rd_t mem_rd;
    logic mem_addr_ok;
    logic mem_data_ok;
    icache_pkg::refill_line_t mem_line;

    // reference model state
    logic [tag_width-1:0] m_tag [icache_pkg::ways][sets];
    logic [sets-1:0] m_valid [icache_pkg::ways];
    logic [sets-1:0] m_lru;

    icache_pkg::fetch_rsp_t exp_rsp_q [$];
    logic exp_hit_q [$];
    icache_pkg::fetch_rsp_t exp_rsp;
    logic exp_hit;
    logic mem_seen;
    int cycle;
    int accept_cyc;
    int issued;
    int rsp_count;
    int checks;
    int errors;
    logic [31:0] lat_state;
    logic [31:0] addr_state;

    icache_top #(.index_width(index_width)) i_dut (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp(rsp), .inval(inval),
        .mem_req(mem_req), .mem_rd(mem_rd),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference functions
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'hc3a50000;
    endfunction

    function automatic icache_pkg::refill_line_t line_at(input logic [31:0] line_addr);
        icache_pkg::refill_line_t l;
        for (int i = 0; i < icache_pkg::line_words; i++) begin
            l[32*i +: 32] = mem_word(line_addr + 4 * i);
        end
        return l;
    endfunction

    // even word starts a pair, odd word stands alone
    function automatic icache_pkg::fetch_rsp_t expected_rsp(input logic [31:0] addr);
        icache_pkg::fetch_rsp_t r;
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        r.pc = addr;
        if (addr[2]) begin
            r.pair_data = {32'h0, mem_word(base)};
            r.pair_ok = 1'b0;
        end else begin
            r.pair_data = {mem_word(base + 32'd4), mem_word(base)};
            r.pair_ok = 1'b1;
        end
        return r;
    endfunction

    // predicts hit or miss and updates tags, valid bits and lru
    task automatic model_lookup(input logic [31:0] addr, output logic hit);
        logic [index_width-1:0] idx;
        logic [tag_width-1:0] tag;
        logic way;
        idx = addr[index_width+3:4];
        tag = addr[31:index_width+4];
        hit = 1'b0;
        way = m_lru[idx];
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            m_tag[way][idx] = tag;
            m_valid[way][idx] = 1'b1;
        end
        m_lru[idx] = ~way;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic fetch(input logic [31:0] addr);
        logic hit;
        model_lookup(addr, hit);
        exp_rsp_q.push_back(expected_rsp(addr));
        exp_hit_q.push_back(hit);
        issued++;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr = addr;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        wait (rsp_count == issued);
    endtask

    // called on a falling edge
    task automatic pulse_inval();
        inval = 1'b1;
        for (int w = 0; w < icache_pkg::ways; w++) begin
            m_valid[w] = '0;
        end
        @(negedge clk);
        inval = 1'b0;
    endtask

    task automatic wait_mem_req();
        @(negedge clk);
        while (!mem_req) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////

    initial begin : memory_model
        logic [31:0] line_addr;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line = '0;
        lat_state = 32'h7fcac047;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                line_addr = mem_rd.line_addr;
                lat_state = lcg_next(lat_state);
                repeat (lat_state[29:28]) @(negedge clk);
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                lat_state = lcg_next(lat_state);
                repeat (lat_state[29:28]) @(negedge clk);
                mem_data_ok = 1'b1;
                mem_line = line_at(line_addr);
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checker
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset) begin
            if (req_valid && req_ready) begin
                accept_cyc = cycle;
            end
            if (mem_req && mem_addr_ok) begin
                checks++;
                // one memory request per missed fetch
                assert (exp_hit_q.size() > 0 && !exp_hit_q[0] && !mem_seen) else begin
                    errors++;
                    $display("memory request at cycle %0d but no miss was outstanding", cycle);
                end
                if (exp_rsp_q.size() > 0) begin
                    checks++;
                    assert (mem_rd.line_addr == {exp_rsp_q[0].pc[31:4], 4'h0}) else begin
                        errors++;
                        $display("ERR mem_rd.line_addr got %h exp %h", mem_rd.line_addr,
                            {exp_rsp_q[0].pc[31:4], 4'h0});
                    end
                end
                mem_seen = 1'b1;
            end
            if (rsp_valid) begin
                checks++;
                assert (exp_rsp_q.size() > 0) else begin
                    errors++;
                    $display("response at cycle %0d with no fetch outstanding", cycle);
                end
                if (exp_rsp_q.size() > 0) begin
                    exp_rsp = exp_rsp_q.pop_front();
                    exp_hit = exp_hit_q.pop_front();
                    checks += 4;
                    assert (rsp.pc == exp_rsp.pc) else begin
                        errors++;
                        $display("ERR rsp.pc got %h exp %h", rsp.pc, exp_rsp.pc);
                    end
                    assert (rsp.pair_data == exp_rsp.pair_data) else begin
                        errors++;
                        $display("ERR rsp.pair_data got %h exp %h", rsp.pair_data,
                            exp_rsp.pair_data);
                    end
                    assert (rsp.pair_ok == exp_rsp.pair_ok) else begin
                        errors++;
                        $display("ERR rsp.pair_ok got %h exp %h", rsp.pair_ok, exp_rsp.pair_ok);
                    end
                    // a hit answers the cycle after acceptance, a miss only after a refill
                    if (exp_hit) begin
                        assert (cycle == accept_cyc + 1 && !mem_seen) else begin
                            errors++;
                            $display("hit on pc %h answered late or after a memory request",
                                exp_rsp.pc);
                        end
                    end else begin
                        assert (mem_seen) else begin
                            errors++;
                            $display("miss on pc %h answered without a memory request",
                                exp_rsp.pc);
                        end
                    end
                end
                mem_seen = 1'b0;
                rsp_count++;
            end
        end
    end

    initial begin : watchdog
        wait (cycle >= max_cycles);
        $display("run stopped after %0d cycles without finishing", cycle);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        logic [31:0] addr;
        reset = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        inval = 1'b0;
        m_valid[0] = '0;
        m_valid[1] = '0;
        m_lru = '0;
        mem_seen = 1'b0;
        cycle = 0;
        accept_cyc = 0;
        issued = 0;
        rsp_count = 0;
        checks = 0;
        errors = 0;
        addr_state = 32'h7fcac047;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state
        @(negedge clk);
        checks += 3;
        assert (req_ready == 1'b1) else begin
            errors++;
            $display("ERR req_ready got %h exp %h", req_ready, 1'b1);
        end
        assert (rsp_valid == 1'b0) else begin
            errors++;
            $display("ERR rsp_valid got %h exp %h", rsp_valid, 1'b0);
        end
        assert (mem_req == 1'b0) else begin
            errors++;
            $display("ERR mem_req got %h exp %h", mem_req, 1'b0);
        end

        // cold miss then hit
        fetch(32'h0000_0100);
        fetch(32'h0000_0100);

        // all four word offsets of one line
        for (int i = 0; i < 4; i++) begin
            fetch(32'h0000_0230 + 4 * i);
        end

        // three tags fighting over set 4
        fetch(32'h0000_1040);
        fetch(32'h0000_2040);
        fetch(32'h0000_1040);
        fetch(32'h0000_2040);
        fetch(32'h0000_3040);
        fetch(32'h0000_2040);
        fetch(32'h0000_1040);

        // invalidate in idle, then during a refill
        @(negedge clk);
        pulse_inval();
        fetch(32'h0000_2040);
        fork
            fetch(32'h0000_3040);
            begin
                wait_mem_req();
                pulse_inval();
            end
        join
        fetch(32'h0000_3040);

        // random fetches over four tags, four sets, four words
        for (int n = 0; n < n_random; n++) begin
            addr_state = lcg_next(addr_state);
            if (addr_state[27:24] == 4'h0) begin
                @(negedge clk);
                pulse_inval();
            end
            addr = 32'h0040_0000;
            addr[9:8] = addr_state[21:20];
            addr[5:4] = addr_state[19:18];
            addr[3:2] = addr_state[17:16];
            fetch(addr);
        end

        repeat (4) @(negedge clk);
        checks++;
        assert (exp_rsp_q.size() == 0) else begin
            errors++;
            $display("%0d fetches never got a response", exp_rsp_q.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- design/icache_data_array.sv
// per-way line storage of the instruction cache, registered read of both ways, line write
`timescale 1ns/1ps

module icache_data_array #(
    parameter int index_width = 4
) (
    input  logic                         clk,
    input  logic [index_width-1:0]       rd_index,
    input  logic [index_width-1:0]       wr_index,
    input  logic [icache_pkg::ways-1:0]  data_we,
    input  icache_pkg::refill_line_t     wr_line,
    output icache_pkg::refill_line_t     line0,
    output icache_pkg::refill_line_t     line1
);

    localparam int sets = 1 << index_width;

    icache_pkg::refill_line_t line_mem [icache_pkg::ways][sets];

    ////////////////////////////////////////////////////////////
    // write port, one way at a time on refill
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (data_we[w]) begin
                line_mem[w][wr_index] <= wr_line;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // both ways read in parallel, way picked later by hit
    always_ff @(posedge clk) begin
        line0 <= line_mem[0][rd_index];
        line1 <= line_mem[1][rd_index];
    end

endmodule

//--- design/icache_pkg.sv
// shared widths and bus bundles of the instruction cache, referenced by scoped name
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////

    // hit vector and lru logic are written for exactly two ways
    localparam int ways = 2;
    localparam int line_words = 4;
    localparam int line_width = 32 * line_words;

    ////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////

    // whole cache line, word 0 in the low bits
    typedef logic [line_width-1:0] refill_line_t;

    // response to the fetch stage
    typedef struct packed {
        logic [31:0] pc;
        // word at pc sits in the low half
        logic [63:0] pair_data;
        // upper instruction usable
        logic        pair_ok;
    } fetch_rsp_t;

    // line read request towards memory
    typedef struct packed {
        // low 4 bits always zero
        logic [31:0] line_addr;
    } mem_rd_t;

endpackage

//--- design/icache_refill_ctrl.sv
// sequencing FSM of the instruction cache covering lookup, miss request, refill and response
`timescale 1ns/1ps

module icache_refill_ctrl #(
    parameter int index_width = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  logic [31:0]                  req_addr,
    input  logic                         inval,
    input  logic [icache_pkg::ways-1:0]  hit,
    input  logic                         victim,
    input  logic                         mem_addr_ok,
    input  logic                         mem_data_ok,
    input  icache_pkg::refill_line_t     mem_line,
    output logic                         req_ready,
    output logic [31:0]                  look_addr,
    output logic [icache_pkg::ways-1:0]  tag_we,
    output logic [icache_pkg::ways-1:0]  data_we,
    output logic                         inval_all,
    output logic                         lru_touch,
    output logic                         rsp_from_refill,
    output icache_pkg::refill_line_t     refill_buf,
    output logic                         rsp_valid,
    output logic                         mem_req,
    output icache_pkg::mem_rd_t          mem_rd
);

    localparam int tag_width = 28 - index_width;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_miss_req,
        s_refill_wait,
        s_respond
    } state_t;

    state_t state;
    state_t state_next;
    logic inval_pend;
    logic accept;
    logic fill;
    logic [icache_pkg::ways-1:0] fill_way;

    // only one fetch in flight, accept in idle with no invalidate due
    assign req_ready = (state == s_idle) && !inval && !inval_pend;
    assign accept = req_valid && req_ready;
    assign inval_all = (state == s_idle) && (inval || inval_pend);

    assign fill = (state == s_refill_wait) && mem_data_ok;
    assign fill_way = victim ? 2'b10 : 2'b01;
    assign tag_we = fill ? fill_way : '0;
    assign data_we = fill ? fill_way : '0;

    assign lru_touch = (state == s_lookup) && (|hit);
    assign rsp_valid = lru_touch || (state == s_respond);
    assign rsp_from_refill = (state == s_respond);

    // line address built from tag and index of the missed fetch
    assign mem_req = (state == s_miss_req);
    assign mem_rd.line_addr = {look_addr[31:32-tag_width], look_addr[index_width+3:4], 4'h0};

    always_comb begin
        state_next = state;
        case (state)
            s_idle:        if (accept) state_next = s_lookup;
            s_lookup:      state_next = (|hit) ? s_idle : s_miss_req;
            s_miss_req:    if (mem_addr_ok) state_next = s_refill_wait;
            s_refill_wait: if (mem_data_ok) state_next = s_respond;
            default:       state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            inval_pend <= 1'b0;
        end else begin
            state <= state_next;
            // invalidate outside idle waits until the fetch is done
            if (state == s_idle) begin
                inval_pend <= 1'b0;
            end else if (inval) begin
                inval_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            look_addr <= req_addr;
        end
        if (fill) begin
            refill_buf <= mem_line;
        end
    end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_rd));

    a_rsp_single: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid);

endmodule

//--- design/icache_tag_array.sv
// per-way tag and valid storage of the instruction cache, registered read and hit compare
`timescale 1ns/1ps

module icache_tag_array #(
    parameter int index_width = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [index_width-1:0]       rd_index,
    input  logic [31:0]                  look_addr,
    input  logic [icache_pkg::ways-1:0]  tag_we,
    input  logic                         inval_all,
    output logic [icache_pkg::ways-1:0]  hit
);

    localparam int sets = 1 << index_width;
    localparam int tag_width = 28 - index_width;

    logic [tag_width-1:0] tag_mem [icache_pkg::ways][sets];
    logic [icache_pkg::ways-1:0][sets-1:0] valid_bits;

    logic [tag_width-1:0] rd_tag [icache_pkg::ways];
    logic [icache_pkg::ways-1:0] rd_valid;

    logic [tag_width-1:0] look_tag;
    logic [index_width-1:0] wr_index;

    assign look_tag = look_addr[31:32-tag_width];
    assign wr_index = look_addr[index_width+3:4];

    ////////////////////////////////////////////////////////////
    // tag storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= look_tag;
            end
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits, cleared by reset and by invalidate
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < icache_pkg::ways; w++) begin
                rd_valid[w] <= valid_bits[w][rd_index];
                if (tag_we[w]) begin
                    valid_bits[w][wr_index] <= 1'b1;
                end
            end
            if (inval_all) begin
                valid_bits <= '0;
            end
        end
    end

    // compare during the lookup cycle
    always_comb begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == look_tag);
        end
    end

    // a refill only ever fills a tag that missed, so no set holds it twice
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        hit[0] |-> !hit[1]);

endmodule

//--- design/icache_top.sv
// top level of the two-way read-only instruction cache, connects arrays, way select and FSM
`timescale 1ns/1ps

module icache_top #(
    parameter int index_width = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  logic [31:0]               req_addr,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output icache_pkg::fetch_rsp_t    rsp,
    input  logic                      inval,
    output logic                      mem_req,
    output icache_pkg::mem_rd_t       mem_rd,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok,
    input  icache_pkg::refill_line_t  mem_line
);

    logic [31:0] look_addr;
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    logic [icache_pkg::ways-1:0] hit;
    logic [icache_pkg::ways-1:0] tag_we;
    logic [icache_pkg::ways-1:0] data_we;
    logic inval_all;
    logic lru_touch;
    logic rsp_from_refill;
    logic victim;
    icache_pkg::refill_line_t refill_buf;
    icache_pkg::refill_line_t line0;
    icache_pkg::refill_line_t line1;

    // arrays read the incoming fetch index at the accept edge
    assign rd_index = req_addr[index_width+3:4];
    assign wr_index = look_addr[index_width+3:4];

    icache_refill_ctrl #(.index_width(index_width)) i_ctrl (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_addr(req_addr), .inval(inval),
        .hit(hit), .victim(victim),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_line(mem_line),
        .req_ready(req_ready), .look_addr(look_addr),
        .tag_we(tag_we), .data_we(data_we), .inval_all(inval_all),
        .lru_touch(lru_touch), .rsp_from_refill(rsp_from_refill),
        .refill_buf(refill_buf), .rsp_valid(rsp_valid),
        .mem_req(mem_req), .mem_rd(mem_rd)
    );

    icache_tag_array #(.index_width(index_width)) i_tags (
        .clk(clk), .reset(reset),
        .rd_index(rd_index), .look_addr(look_addr),
        .tag_we(tag_we), .inval_all(inval_all), .hit(hit)
    );

    icache_data_array #(.index_width(index_width)) i_data (
        .clk(clk),
        .rd_index(rd_index), .wr_index(wr_index),
        .data_we(data_we), .wr_line(mem_line),
        .line0(line0), .line1(line1)
    );

    icache_way_select #(.index_width(index_width)) i_way_sel (
        .clk(clk), .reset(reset),
        .look_addr(look_addr), .hit(hit),
        .line0(line0), .line1(line1), .refill_buf(refill_buf),
        .rsp_from_refill(rsp_from_refill), .lru_touch(lru_touch), .tag_we(tag_we),
        .victim(victim), .rsp(rsp)
    );

endmodule

//--- design/icache_way_select.sv
// lru state, victim choice and response assembly of the instruction cache
`timescale 1ns/1ps

module icache_way_select #(
    parameter int index_width = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [31:0]                  look_addr,
    input  logic [icache_pkg::ways-1:0]  hit,
    input  icache_pkg::refill_line_t     line0,
    input  icache_pkg::refill_line_t     line1,
    input  icache_pkg::refill_line_t     refill_buf,
    input  logic                         rsp_from_refill,
    input  logic                         lru_touch,
    input  logic [icache_pkg::ways-1:0]  tag_we,
    output logic                         victim,
    output icache_pkg::fetch_rsp_t       rsp
);

    localparam int sets = 1 << index_width;
    localparam int off_width = $clog2(icache_pkg::line_words);

    // one bit per set, holds the way to evict next
    logic [sets-1:0] lru_victim;
    logic [index_width-1:0] look_index;
    logic recent_way;

    icache_pkg::refill_line_t sel_line;
    logic [31:0] words [icache_pkg::line_words];
    logic [off_width-1:0] word_off;

    assign look_index = look_addr[index_width+3:4];
    assign word_off = look_addr[off_width+1:2];

    ////////////////////////////////////////////////////////////
    // lru
    ////////////////////////////////////////////////////////////

    assign victim = lru_victim[look_index];
    // hit way on a touch, else the way being filled
    assign recent_way = lru_touch ? hit[1] : tag_we[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_victim <= '0;
        end else if (lru_touch || (|tag_we)) begin
            lru_victim[look_index] <= ~recent_way;
        end
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (rsp_from_refill) begin
            sel_line = refill_buf;
        end else if (hit[1]) begin
            sel_line = line1;
        end else begin
            sel_line = line0;
        end
        for (int i = 0; i < icache_pkg::line_words; i++) begin
            words[i] = sel_line[32*i +: 32];
        end
    end

    // pairs only start on even words, odd offsets give a single instruction
    always_comb begin
        rsp.pc = look_addr;
        if (word_off[0]) begin
            rsp.pair_data = {32'h0, words[word_off]};
            rsp.pair_ok = 1'b0;
        end else begin
            rsp.pair_data = {words[word_off + 1'b1], words[word_off]};
            rsp.pair_ok = 1'b1;
        end
    end

endmodule

//--- sim.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_way_select.sv
design/icache_refill_ctrl.sv
design/icache_top.sv
bench/icache_tb.sv
